//--- amo_alu.sv
// Purely combinational 32-bit ALU for atomic operations.
// Non read-modify-write operations produce zero.
`default_nettype none
`timescale 1ns/10ps

module amo_alu (
  input  amo_pkg::amo_op_e amo_op_i,
  input  logic [31:0]      operand_a_i,
  input  logic [31:0]      operand_b_i,
  output logic [31:0]      result_o
);

  import amo_pkg::*;

  logic        is_signed;
  logic        is_sub;
  logic [32:0] adder_a;
  logic [32:0] adder_b;
  logic [32:0] adder_sum;
  logic        a_less_b;

  // --------------------------------------------------
  // Shared adder
  // --------------------------------------------------
  // Signed compares sign extend, unsigned compares zero extend.
  assign is_signed = (amo_op_i == AmoMax) || (amo_op_i == AmoMin);
  assign is_sub    = (amo_op_i inside {AmoMax, AmoMaxu, AmoMin, AmoMinu});

  assign adder_a = {is_signed & operand_a_i[31], operand_a_i};
  // Subtraction as inverted operand plus carry in.
  assign adder_b = is_sub ? ~{is_signed & operand_b_i[31], operand_b_i}
                          :  {is_signed & operand_b_i[31], operand_b_i};

  assign adder_sum = adder_a + adder_b + {32'h0, is_sub};
  // The 33-bit difference cannot overflow, so its sign bit is the compare.
  assign a_less_b  = adder_sum[32];

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------
  always_comb begin
    unique case (amo_op_i)
      AmoSwap: result_o = operand_b_i;
      AmoAdd:  result_o = adder_sum[31:0];
      AmoAnd:  result_o = operand_a_i & operand_b_i;
      AmoOr:   result_o = operand_a_i | operand_b_i;
      AmoXor:  result_o = operand_a_i ^ operand_b_i;
      AmoMax, AmoMaxu: result_o = a_less_b ? operand_b_i : operand_a_i;
      AmoMin, AmoMinu: result_o = a_less_b ? operand_a_i : operand_b_i;
      default: result_o = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

//--- amo_bank.f
tcdm_pkg.sv
amo_pkg.sv
amo_alu.sv
amo_reservation.sv
amo_shim.sv
sram_bank.sv
amo_status_regs.sv
amo_bank_top.sv
tb_amo_bank.sv

//--- amo_bank_top.sv
// One shared bank with its atomic shim and the conflict status block.
// Requests carry word addresses; DMA requests must not be atomic operations.
`default_nettype none
`timescale 1ns/10ps

module amo_bank_top #(
  parameter int unsigned AddrWidth   = tcdm_pkg::DefaultAddrWidth,
  parameter int unsigned DataWidth   = tcdm_pkg::DefaultDataWidth,
  parameter int unsigned CoreIdWidth = tcdm_pkg::DefaultCoreIdWidth,
  parameter int unsigned NumWords    = 2 ** AddrWidth,
  parameter int unsigned CountWidth  = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  logic                   dma_access_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  amo_pkg::amo_op_e       amo_i,
  input  logic                   write_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [DataWidth/8-1:0] wstrb_i,
  input  logic [CoreIdWidth-1:0] core_id_i,
  input  logic                   is_core_i,
  output logic [DataWidth-1:0]   rdata_o,
  input  logic                   conflict_clear_i,
  output logic [CountWidth-1:0]  conflict_count_o,
  output logic                   conflict_flag_o
);

  localparam int unsigned StrbWidth = DataWidth / 8;

  // Bank port.
  logic                 mem_req;
  logic [AddrWidth-1:0] mem_addr;
  logic                 mem_wen;
  logic [DataWidth-1:0] mem_wdata;
  logic [StrbWidth-1:0] mem_be;
  logic [DataWidth-1:0] mem_rdata;
  logic                 amo_conflict;

  amo_shim #(
    .AddrWidth   (AddrWidth),
    .DataWidth   (DataWidth),
    .CoreIdWidth (CoreIdWidth)
  ) u_shim (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .dma_access_i   (dma_access_i),
    .addr_i         (addr_i),
    .amo_i          (amo_i),
    .write_i        (write_i),
    .wdata_i        (wdata_i),
    .wstrb_i        (wstrb_i),
    .core_id_i      (core_id_i),
    .is_core_i      (is_core_i),
    .ready_o        (ready_o),
    .rdata_o        (rdata_o),
    .mem_req_o      (mem_req),
    .mem_addr_o     (mem_addr),
    .mem_wen_o      (mem_wen),
    .mem_wdata_o    (mem_wdata),
    .mem_be_o       (mem_be),
    .mem_rdata_i    (mem_rdata),
    .amo_conflict_o (amo_conflict)
  );

  sram_bank #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .NumWords  (NumWords)
  ) u_bank (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .addr_i  (mem_addr),
    .wen_i   (mem_wen),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

  // Observes the shim only, nothing feeds back.
  amo_status_regs #(
    .CountWidth (CountWidth)
  ) u_status (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .conflict_i (amo_conflict),
    .clear_i    (conflict_clear_i),
    .count_o    (conflict_count_o),
    .flag_o     (conflict_flag_o)
  );

endmodule

`default_nettype wire

//--- amo_pkg.sv
// Atomic memory operation encoding in the RISC-V A-extension style.
// LR and SC are handled by the reservation logic and are not read-modify-write.
`default_nettype none

package amo_pkg;

  // Operation carried with every request. Plain loads and stores use AmoNone.
  typedef enum logic [3:0] {
    AmoNone,
    AmoSwap,
    AmoAdd,
    AmoAnd,
    AmoOr,
    AmoXor,
    AmoMax,
    AmoMaxu,
    AmoMin,
    AmoMinu,
    AmoLr,
    AmoSc
  } amo_op_e;

  // True for operations that need the read, compute and write-back sequence.
  function automatic logic is_rmw(amo_op_e op);
    return !(op inside {AmoNone, AmoLr, AmoSc});
  endfunction

endpackage

`default_nettype wire

//--- amo_reservation.sv
// LR/SC reservation tracker, one reservation per bank at word granularity.
// Only accepted requests (req_fire_i) update the reservation.
`default_nettype none
`timescale 1ns/10ps

module amo_reservation #(
  parameter int unsigned AddrWidth   = tcdm_pkg::DefaultAddrWidth,
  parameter int unsigned CoreIdWidth = tcdm_pkg::DefaultCoreIdWidth
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_fire_i,
  input  logic                   dma_access_i,
  input  logic                   is_core_i,
  input  logic [CoreIdWidth-1:0] core_id_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  amo_pkg::amo_op_e       amo_i,
  input  logic                   write_i,
  output logic                   sc_success_o
);

  import amo_pkg::*;

  logic                   res_valid_q;
  logic                   res_valid_d;
  logic [AddrWidth-1:0]   res_addr_q;
  logic [CoreIdWidth-1:0] res_core_q;

  logic set_res;
  logic kill_res;
  logic sc_owner;
  logic foreign;
  logic modifies;

  always_comb begin
    // Any store or read-modify-write changes the word.
    modifies = write_i | is_rmw(amo_i);
    // Other cores, the DMA and non-core masters count as foreign.
    foreign  = !is_core_i || dma_access_i || (core_id_i != res_core_q);

    // A held reservation is only replaced by its owner, which avoids live-lock.
    set_res  = req_fire_i && (amo_i == AmoLr) &&
               (!res_valid_q || (res_core_q == core_id_i));
    kill_res = req_fire_i && res_valid_q && foreign && modifies &&
               (addr_i == res_addr_q);
    // Any SC by the owner ends the reservation, matching address or not.
    sc_owner = req_fire_i && res_valid_q && (amo_i == AmoSc) &&
               (res_core_q == core_id_i);

    sc_success_o = sc_owner && (addr_i == res_addr_q);

    res_valid_d = res_valid_q;
    if (set_res) res_valid_d = 1'b1;
    if (kill_res || sc_owner) res_valid_d = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= res_valid_d;
    end
  end

  // Address and owner are only meaningful while the valid bit is set.
  always_ff @(posedge clk_i) begin
    if (set_res) begin
      res_addr_q <= addr_i;
      res_core_q <= core_id_i;
    end
  end

endmodule

`default_nettype wire

//--- amo_shim.sv
// Atomic shim in front of one bank. DMA requests always win the bank port.
// Atomic operations work on one 32-bit lane chosen by wstrb_i; DataWidth is 32 or 64.
// Software must keep DMA away from words under an atomic operation.
`default_nettype none
`timescale 1ns/10ps

module amo_shim #(
  parameter int unsigned AddrWidth   = tcdm_pkg::DefaultAddrWidth,
  parameter int unsigned DataWidth   = tcdm_pkg::DefaultDataWidth,
  parameter int unsigned CoreIdWidth = tcdm_pkg::DefaultCoreIdWidth
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  logic                   dma_access_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  amo_pkg::amo_op_e       amo_i,
  input  logic                   write_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [DataWidth/8-1:0] wstrb_i,
  input  logic [CoreIdWidth-1:0] core_id_i,
  input  logic                   is_core_i,
  output logic                   ready_o,
  output logic [DataWidth-1:0]   rdata_o,
  output logic                   mem_req_o,
  output logic [AddrWidth-1:0]   mem_addr_o,
  output logic                   mem_wen_o,
  output logic [DataWidth-1:0]   mem_wdata_o,
  output logic [DataWidth/8-1:0] mem_be_o,
  input  logic [DataWidth-1:0]   mem_rdata_i,
  output logic                   amo_conflict_o
);

  import amo_pkg::*;

  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef enum logic [1:0] {
    StIdle,
    StCompute,
    StWriteBack
  } state_e;

  state_e               state_q;
  state_e               state_d;
  amo_op_e              amo_op_q;
  logic [AddrWidth-1:0] addr_q;
  logic                 idx_d;
  logic                 idx_q;
  logic [31:0]          operand_a;
  logic [31:0]          operand_b_q;
  logic [31:0]          amo_result;
  logic [31:0]          amo_result_q;
  logic                 req_fire;
  logic                 load_amo;
  logic                 sc_success;
  logic                 sc_success_q;
  logic                 sc_q;

  // Core side of the bank port, before the DMA override.
  logic                 core_ready;
  logic                 core_req;
  logic [AddrWidth-1:0] core_addr;
  logic                 core_wen;
  logic [DataWidth-1:0] core_wdata;
  logic [StrbWidth-1:0] core_be;

  // --------------------------------------------------
  // DMA priority multiplexer
  // --------------------------------------------------
  always_comb begin
    if (dma_access_i) begin
      ready_o     = 1'b1;
      mem_req_o   = valid_i;
      mem_addr_o  = addr_i;
      mem_wen_o   = write_i;
      mem_wdata_o = wdata_i;
      mem_be_o    = wstrb_i;
    end else begin
      ready_o     = core_ready;
      mem_req_o   = core_req;
      mem_addr_o  = core_addr;
      mem_wen_o   = core_wen;
      mem_wdata_o = core_wdata;
      mem_be_o    = core_be;
    end
  end

  assign req_fire = valid_i & ready_o;
  assign load_amo = req_fire & ~dma_access_i & is_rmw(amo_i);

  // The upper strobe half selects the upper lane of a 64-bit word.
  assign idx_d     = (DataWidth == 64) ? wstrb_i[StrbWidth/2] : 1'b0;
  assign operand_a = mem_rdata_i[32*idx_q +: 32];

  // SC replaces the bank data with 0 on success, 1 on failure, per lane.
  assign rdata_o = sc_q ? {(DataWidth / 32){{31'h0, ~sc_success_q}}} : mem_rdata_i;

  assign amo_conflict_o = valid_i & dma_access_i & (state_q != StIdle) &
                          (addr_i == addr_q);

  // --------------------------------------------------
  // Atomic sequencer
  // --------------------------------------------------
  always_comb begin
    // Plain pass-through, SC stores only on success.
    core_ready = 1'b1;
    core_req   = valid_i;
    core_addr  = addr_i;
    core_wen   = write_i | sc_success;
    core_wdata = wdata_i;
    core_be    = wstrb_i;
    state_d    = state_q;

    unique case (state_q)
      StIdle: begin
        // Old value is read in the accepting cycle.
        if (load_amo) state_d = StCompute;
      end
      StCompute: begin
        core_ready = 1'b0;
        core_req   = 1'b0;
        state_d    = StWriteBack;
      end
      StWriteBack: begin
        core_ready = 1'b0;
        core_req   = 1'b1;
        core_addr  = addr_q;
        core_wen   = 1'b1;
        core_wdata = '0;
        core_wdata[32*idx_q +: 32] = amo_result_q;
        core_be    = '0;
        core_be[4*idx_q +: 4] = 4'hf;
        // Write-back retires in the first cycle the DMA leaves the port.
        if (!dma_access_i) state_d = StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= StIdle;
      sc_q         <= 1'b0;
      sc_success_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      sc_q         <= req_fire & (amo_i == AmoSc);
      sc_success_q <= sc_success;
    end
  end

  // Operation context captured on acceptance.
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      amo_op_q    <= amo_i;
      addr_q      <= addr_i;
      idx_q       <= idx_d;
      operand_b_q <= wdata_i[32*idx_d +: 32];
    end
    if (state_q == StCompute) begin
      amo_result_q <= amo_result;
    end
  end

  amo_alu u_alu (
    .amo_op_i    (amo_op_q),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b_q),
    .result_o    (amo_result)
  );

  amo_reservation #(
    .AddrWidth   (AddrWidth),
    .CoreIdWidth (CoreIdWidth)
  ) u_reservation (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_fire_i   (req_fire),
    .dma_access_i (dma_access_i),
    .is_core_i    (is_core_i),
    .core_id_i    (core_id_i),
    .addr_i       (addr_i),
    .amo_i        (amo_i),
    .write_i      (write_i),
    .sc_success_o (sc_success)
  );

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  // Request-side rules the masters must follow.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && dma_access_i |-> amo_i == AmoNone);
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && (amo_i != AmoNone) |-> !write_i);
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && is_rmw(amo_i) |-> wstrb_i[4*idx_d +: 4] == 4'hf);
  assert property (@(posedge clk_i)
    (DataWidth == 32) || (DataWidth == 64));

endmodule

`default_nettype wire

//--- amo_status_regs.sv
// Conflict counter and sticky flag for DMA hits on an in-flight atomic operation.
// The counter saturates. A clear strobe wins over a new conflict in the same cycle.
`default_nettype none
`timescale 1ns/10ps

module amo_status_regs #(
  parameter int unsigned CountWidth = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  conflict_i,
  input  logic                  clear_i,
  output logic [CountWidth-1:0] count_o,
  output logic                  flag_o
);

  logic [CountWidth-1:0] count_q;
  logic                  flag_q;
  logic                  at_max;

  assign at_max = &count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      count_q <= '0;
      flag_q  <= 1'b0;
    end else if (conflict_i) begin
      // Hold at the top instead of wrapping.
      if (!at_max) count_q <= count_q + 1'b1;
      flag_q <= 1'b1;
    end
  end

  assign count_o = count_q;
  assign flag_o  = flag_q;

  // Without a clear the count only moves up.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !clear_i |=> count_q >= $past(count_q));

endmodule

`default_nettype wire

//--- sram_bank.sv
// Single-port word-addressed bank model with byte enables.
// Read data appears one cycle after a read request and holds until the next read.
`default_nettype none
`timescale 1ns/10ps

module sram_bank #(
  parameter int unsigned AddrWidth = tcdm_pkg::DefaultAddrWidth,
  parameter int unsigned DataWidth = tcdm_pkg::DefaultDataWidth,
  parameter int unsigned NumWords  = 2 ** AddrWidth
) (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  logic                   wen_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [DataWidth/8-1:0] be_i,
  output logic [DataWidth-1:0]   rdata_o
);

  localparam int unsigned StrbWidth = DataWidth / 8;

  logic [DataWidth-1:0] mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (wen_i) begin
        // Only the enabled bytes change.
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_amo_bank.sv
// Directed testbench for the shared bank with its atomic shim, DataWidth 64.
// Expected values come from a reference memory and a local copy of the atomic rules.
// Every word is fully written before it is read, since the bank is not reset.
`default_nettype none
`timescale 1ns/10ps

module tb_amo_bank;

  import tcdm_pkg::*;
  import amo_pkg::*;

  localparam int unsigned AddrWidth   = DefaultAddrWidth;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned CoreIdWidth = DefaultCoreIdWidth;
  localparam int unsigned NumWords    = 2 ** AddrWidth;
  localparam int unsigned CountWidth  = 8;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  // Cycles a request may wait for ready_o.
  localparam int unsigned Timeout     = 20;

  logic                   clk;
  logic                   rst_n;
  logic                   valid;
  logic                   ready;
  logic                   dma_access;
  logic [AddrWidth-1:0]   addr;
  amo_op_e                amo;
  logic                   wr;
  logic [DataWidth-1:0]   wdata;
  logic [StrbWidth-1:0]   wstrb;
  logic [CoreIdWidth-1:0] core_id;
  logic                   is_core;
  logic [DataWidth-1:0]   rdata;
  logic                   conflict_clear;
  logic [CountWidth-1:0]  conflict_count;
  logic                   conflict_flag;

  // Reference memory and random state.
  logic [DataWidth-1:0] ref_mem [NumWords];
  logic [31:0]          lcg_state = 32'h45bbe183;

  amo_bank_top #(
    .AddrWidth   (AddrWidth),
    .DataWidth   (DataWidth),
    .CoreIdWidth (CoreIdWidth),
    .NumWords    (NumWords),
    .CountWidth  (CountWidth)
  ) u_amo_bank_top (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .valid_i          (valid),
    .ready_o          (ready),
    .dma_access_i     (dma_access),
    .addr_i           (addr),
    .amo_i            (amo),
    .write_i          (wr),
    .wdata_i          (wdata),
    .wstrb_i          (wstrb),
    .core_id_i        (core_id),
    .is_core_i        (is_core),
    .rdata_o          (rdata),
    .conflict_clear_i (conflict_clear),
    .conflict_count_o (conflict_count),
    .conflict_flag_o  (conflict_flag)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // New lane value of a read-modify-write operation.
  function automatic logic [31:0] amo_expect(amo_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      AmoSwap: return b;
      AmoAdd:  return a + b;
      AmoAnd:  return a & b;
      AmoOr:   return a | b;
      AmoXor:  return a ^ b;
      AmoMax:  return ($signed(a) > $signed(b)) ? a : b;
      AmoMaxu: return (a > b) ? a : b;
      AmoMin:  return ($signed(a) < $signed(b)) ? a : b;
      AmoMinu: return (a < b) ? a : b;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [DataWidth-1:0] merge_bytes(logic [DataWidth-1:0] old_word,
                                                       logic [DataWidth-1:0] new_word,
                                                       logic [StrbWidth-1:0] strb);
    logic [DataWidth-1:0] word;
    word = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) word[8*b +: 8] = new_word[8*b +: 8];
    end
    return word;
  endfunction

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error: %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  // SC result is 0 on success and 1 on failure in every 32-bit lane.
  task automatic check_sc(input logic [DataWidth-1:0] got, input bit exp_fail);
    logic [31:0] exp_lane;
    exp_lane = {31'h0, exp_fail};
    for (int l = 0; l < DataWidth / 32; l++) begin
      if (got[32*l +: 32] !== exp_lane) begin
        stop_with_failure($sformatf("error: rdata_o lane %0d expected 0x%h got 0x%h",
                                    l, exp_lane, got[32*l +: 32]));
      end
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error: %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_count(input logic [CountWidth-1:0] got, input logic [CountWidth-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error: conflict_count_o expected 0x%h got 0x%h", exp, got));
    end
  endtask

  // --------------------------------------------------
  // Request driving
  // --------------------------------------------------
  task automatic drive_idle();
    valid          = 1'b0;
    dma_access     = 1'b0;
    addr           = '0;
    amo            = AmoNone;
    wr             = 1'b0;
    wdata          = '0;
    wstrb          = '0;
    core_id        = '0;
    is_core        = 1'b1;
    conflict_clear = 1'b0;
  endtask

  // Returns 1 ns after the edge that follows acceptance.
  task automatic wait_accept();
    int unsigned cycles;
    cycles = 0;
    #1;
    while (ready !== 1'b1) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > Timeout) stop_with_failure("ready_o stayed low, request never accepted");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send(input logic [AddrWidth-1:0] req_addr, input amo_op_e req_op,
                      input logic req_wr, input logic [DataWidth-1:0] req_data,
                      input logic [StrbWidth-1:0] req_strb,
                      input logic [CoreIdWidth-1:0] req_id);
    valid      = 1'b1;
    dma_access = 1'b0;
    addr       = req_addr;
    amo        = req_op;
    wr         = req_wr;
    wdata      = req_data;
    wstrb      = req_strb;
    core_id    = req_id;
    is_core    = 1'b1;
    wait_accept();
    drive_idle();
  endtask

  task automatic write_word(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] d,
                            input logic [StrbWidth-1:0] s, input logic [CoreIdWidth-1:0] id);
    send(a, AmoNone, 1'b1, d, s, id);
    ref_mem[a] = merge_bytes(ref_mem[a], d, s);
  endtask

  task automatic read_and_check(input logic [AddrWidth-1:0] a);
    send(a, AmoNone, 1'b0, '0, '1, '0);
    check_data("rdata_o", rdata, ref_mem[a]);
  endtask

  // Returns in the compute cycle, after the old word was checked.
  task automatic run_amo(input logic [AddrWidth-1:0] a, input amo_op_e op, input int lane,
                         input logic [31:0] opb, input logic [CoreIdWidth-1:0] id);
    logic [DataWidth-1:0] old_word;
    logic [DataWidth-1:0] new_word;
    logic [StrbWidth-1:0] strb;
    old_word = ref_mem[a];
    new_word = old_word;
    new_word[32*lane +: 32] = amo_expect(op, old_word[32*lane +: 32], opb);
    strb = (lane == 0) ? 8'h0f : 8'hf0;
    send(a, op, 1'b0, {opb, opb}, strb, id);
    check_data("rdata_o", rdata, old_word);
    ref_mem[a] = new_word;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_plain_access();
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r = next_rand();
      write_word(AddrWidth'(16 + i), {next_rand(), next_rand()}, 8'hff, CoreIdWidth'(i));
      write_word(AddrWidth'(16 + i), {next_rand(), next_rand()}, r[7:0], CoreIdWidth'(i));
    end
    // Back-to-back reads.
    for (int i = 0; i < 4; i++) begin
      read_and_check(AddrWidth'(16 + i));
    end
  endtask

  task automatic test_atomic_ops();
    logic [AddrWidth-1:0] a;
    logic [31:0]          r0;
    logic [31:0]          r1;
    logic [31:0]          old_a;
    logic [31:0]          opb;
    logic [31:0]          other;
    for (int k = 1; k <= 9; k++) begin
      for (int lane = 0; lane < 2; lane++) begin
        a  = AddrWidth'(64 + 2 * k + lane);
        r0 = next_rand();
        r1 = next_rand();
        // Opposite signs, so signed and unsigned compares disagree.
        old_a = (lane == 0) ? (r0 | 32'h8000_0000) : (r0 & 32'h7fff_ffff);
        opb   = (lane == 0) ? (r1 & 32'h7fff_ffff) : (r1 | 32'h8000_0000);
        other = next_rand();
        write_word(a, (lane == 0) ? {other, old_a} : {old_a, other}, 8'hff, '0);
        run_amo(a, amo_op_e'(k), lane, opb, 2'd1);
        read_and_check(a);
      end
    end
  endtask

  task automatic test_lr_sc();
    logic [AddrWidth-1:0] a;
    logic [DataWidth-1:0] d;
    a = AddrWidth'(128);
    write_word(a, {next_rand(), next_rand()}, 8'hff, '0);
    // LR then SC by the same core stores.
    send(a, AmoLr, 1'b0, '0, 8'hff, 2'd1);
    check_data("rdata_o", rdata, ref_mem[a]);
    d = {next_rand(), next_rand()};
    send(a, AmoSc, 1'b0, d, 8'hff, 2'd1);
    check_sc(rdata, 1'b0);
    ref_mem[a] = d;
    read_and_check(a);
    // A store by another core breaks the reservation.
    send(a, AmoLr, 1'b0, '0, 8'hff, 2'd1);
    write_word(a, {next_rand(), next_rand()}, 8'h3c, 2'd2);
    send(a, AmoSc, 1'b0, {next_rand(), next_rand()}, 8'hff, 2'd1);
    check_sc(rdata, 1'b1);
    read_and_check(a);
    // No reservation held.
    send(a, AmoSc, 1'b0, {next_rand(), next_rand()}, 8'hff, 2'd0);
    check_sc(rdata, 1'b1);
    read_and_check(a);
  endtask

  task automatic test_dma_priority();
    logic [AddrWidth-1:0] a;
    logic [AddrWidth-1:0] y;
    logic [DataWidth-1:0] d;
    a = AddrWidth'(192);
    y = AddrWidth'(193);
    write_word(a, {next_rand(), next_rand()}, 8'hff, '0);
    write_word(y, {next_rand(), next_rand()}, 8'hff, '0);
    d = {next_rand(), next_rand()};
    run_amo(a, AmoAdd, 1, next_rand(), 2'd3);
    // Write-back starts one cycle after compute.
    @(posedge clk);
    #1;
    valid      = 1'b1;
    dma_access = 1'b1;
    is_core    = 1'b0;
    addr       = y;
    wr         = 1'b1;
    wdata      = d;
    wstrb      = 8'hff;
    #1;
    check_bit("ready_o", ready, 1'b1);
    @(posedge clk);
    #1;
    ref_mem[y] = d;
    // Core read of the atomic word must wait for the pending write-back.
    dma_access = 1'b0;
    is_core    = 1'b1;
    addr       = a;
    wr         = 1'b0;
    #1;
    check_bit("ready_o", ready, 1'b0);
    wait_accept();
    drive_idle();
    check_data("rdata_o", rdata, ref_mem[a]);
    read_and_check(y);
  endtask

  task automatic test_conflict_count();
    logic [AddrWidth-1:0]  a;
    logic [CountWidth-1:0] hits;
    a    = AddrWidth'(256);
    hits = '0;
    write_word(a, {next_rand(), next_rand()}, 8'hff, '0);
    check_count(conflict_count, '0);
    run_amo(a, AmoXor, 0, next_rand(), 2'd2);
    // DMA reads of the in-flight word, one per cycle.
    for (int i = 0; i < 3; i++) begin
      valid      = 1'b1;
      dma_access = 1'b1;
      is_core    = 1'b0;
      addr       = a;
      wr         = 1'b0;
      wstrb      = '1;
      hits++;
      @(posedge clk);
      #1;
    end
    drive_idle();
    read_and_check(a);
    check_count(conflict_count, hits);
    check_bit("conflict_flag_o", conflict_flag, 1'b1);
    conflict_clear = 1'b1;
    @(posedge clk);
    #1;
    conflict_clear = 1'b0;
    check_count(conflict_count, '0);
    check_bit("conflict_flag_o", conflict_flag, 1'b0);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    drive_idle();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_count(conflict_count, '0);
    check_bit("conflict_flag_o", conflict_flag, 1'b0);
    check_bit("ready_o", ready, 1'b1);
    test_plain_access();
    test_atomic_ops();
    test_lr_sc();
    test_dma_priority();
    test_conflict_count();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tcdm_pkg.sv
// Memory-side defaults shared by the bank, the atomic shim and the top level.
// Addresses are word addresses. The data width must be 32 or 64 bits.
`default_nettype none

package tcdm_pkg;

  // Word address width of one bank.
  localparam int unsigned DefaultAddrWidth = 10;

  // Bank word width, 32 or 64.
  localparam int unsigned DefaultDataWidth = 64;

  // Width of the id that a requesting core presents.
  localparam int unsigned DefaultCoreIdWidth = 2;

endpackage

`default_nettype wire
